//--- rtl/gfx_mem_pkg.sv
package gfx_mem_pkg;

	localparam int gfx_addr_w = 16;
	localparam int bank_addr_w = 14;
	localparam int bank_sel_w = gfx_addr_w - bank_addr_w; // bank select in top bits
	localparam int gfx_data_w = 16;
	localparam int bank_depth = 1 << bank_addr_w;

	localparam int num_clients = 4;
	localparam int num_banks = 4;

	typedef logic [gfx_addr_w-1:0] gfx_addr_t;
	typedef logic [bank_addr_w-1:0] bank_addr_t;
	typedef logic [gfx_data_w-1:0] gfx_data_t;

	// order is priority order, sprite wins
	typedef enum logic [1:0] {
		client_sprite = 2'd0,
		client_bg0 = 2'd1,
		client_bg1 = 2'd2,
		client_ov = 2'd3
	} client_e;

	typedef enum logic [2:0] {
		s_idle = 3'd0,
		s_grant_sp = 3'd1,
		s_grant_bg0 = 3'd2,
		s_grant_bg1 = 3'd3,
		s_grant_ov = 3'd4
	} arb_state_e;

	typedef gfx_addr_t [num_clients-1:0] client_addr_vec_t; // indexed by client_e

	function automatic logic [bank_sel_w-1:0] bank_of(gfx_addr_t a);
		return a[gfx_addr_w-1:bank_addr_w];
	endfunction

	function automatic bank_addr_t offset_of(gfx_addr_t a);
		return a[bank_addr_w-1:0];
	endfunction

endpackage

//--- rtl/vram_bank_if.sv
interface vram_bank_if;
	import gfx_mem_pkg::*;

	bank_addr_t addr; // word offset inside bank
	logic valid;
	gfx_data_t dout;
	logic ready; // dout matches addr

	modport arbiter (
		output addr,
		output valid,
		input dout,
		input ready
	);

	modport bank (
		input addr,
		input valid,
		output dout,
		output ready
	);

endinterface

//--- rtl/gfx_read_if.sv
interface gfx_read_if;
	import gfx_mem_pkg::*;

	gfx_addr_t address; // bank select plus offset
	logic rvalid; // held until rready
	gfx_data_t data; // zero while rready low
	logic rready;

	modport client (
		output address,
		output rvalid,
		input data,
		input rready
	);

	modport memory (
		input address,
		input rvalid,
		output data,
		output rready
	);

endinterface

//--- rtl/bank_arbiter.sv
module bank_arbiter #(
	parameter int bank_id = 0
) (
	input logic CLK,
	input logic RSTb,
	input logic [gfx_mem_pkg::num_clients-1:0] rvalid,
	input gfx_mem_pkg::client_addr_vec_t address,
	vram_bank_if.arbiter bank,
	output logic [gfx_mem_pkg::num_clients-1:0] grant_ready,
	output gfx_mem_pkg::gfx_data_t grant_data [gfx_mem_pkg::num_clients]
);
	import gfx_mem_pkg::*;

	arb_state_e state;
	arb_state_e state_next;
	logic [num_clients-1:0] hit; // requests aimed at this bank
	client_e pick; // highest priority hit
	client_e owner; // client held by current grant state
	logic owner_ready;

	always_comb begin
		for (int i = 0; i < num_clients; i++) begin
			hit[i] = rvalid[i] && (bank_of(address[i]) == bank_sel_w'(bank_id));
		end
	end

	// scan from lowest priority so the last hit wins
	always_comb begin
		pick = client_ov;
		for (int i = num_clients - 1; i >= 0; i--) begin
			if (hit[i]) begin
				pick = client_e'(i);
			end
		end
	end

	always_comb begin
		case (state)
			s_grant_bg0: owner = client_bg0;
			s_grant_bg1: owner = client_bg1;
			s_grant_ov: owner = client_ov;
			default: owner = client_sprite;
		endcase
	end

	assign owner_ready = bank.ready && rvalid[owner];

	always_comb begin
		state_next = state;
		bank.valid = 1'b0;
		bank.addr = '0;
		grant_ready = '0;
		for (int i = 0; i < num_clients; i++) begin
			grant_data[i] = '0;
		end

		if (state == s_idle) begin
			if (|hit) begin
				bank.valid = 1'b1; // same cycle as rvalid
				bank.addr = offset_of(address[pick]);
				case (pick)
					client_sprite: state_next = s_grant_sp;
					client_bg0: state_next = s_grant_bg0;
					client_bg1: state_next = s_grant_bg1;
					default: state_next = s_grant_ov;
				endcase
			end
		end else begin
			bank.valid = rvalid[owner];
			bank.addr = offset_of(address[owner]);
			grant_ready[owner] = owner_ready;
			if (owner_ready) begin
				grant_data[owner] = bank.dout;
			end
			if (!rvalid[owner]) begin
				state_next = s_idle; // client let go
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= s_idle;
		end else begin
			state <= state_next;
		end
	end

endmodule

//--- rtl/gfx_memory_arbiter.sv
module gfx_memory_arbiter (
	input logic CLK,
	input logic RSTb,

	gfx_read_if.memory sprite,
	gfx_read_if.memory bg0,
	gfx_read_if.memory bg1,
	gfx_read_if.memory ov,

	vram_bank_if.arbiter bank0,
	vram_bank_if.arbiter bank1,
	vram_bank_if.arbiter bank2,
	vram_bank_if.arbiter bank3
);
	import gfx_mem_pkg::*;

	logic [num_clients-1:0] rvalid;
	client_addr_vec_t address;

	logic [num_clients-1:0] bank_ready [num_banks];
	gfx_data_t bank_data [num_banks][num_clients]; // zero unless granted

	logic [num_clients-1:0] client_ready;
	gfx_data_t client_data [num_clients];

	// request view shared by all bank arbiters
	assign rvalid[client_sprite] = sprite.rvalid;
	assign rvalid[client_bg0] = bg0.rvalid;
	assign rvalid[client_bg1] = bg1.rvalid;
	assign rvalid[client_ov] = ov.rvalid;

	assign address[client_sprite] = sprite.address;
	assign address[client_bg0] = bg0.address;
	assign address[client_bg1] = bg1.address;
	assign address[client_ov] = ov.address;

	bank_arbiter #(.bank_id(0)) bank_arbiter_0 (
		.CLK(CLK),
		.RSTb(RSTb),
		.rvalid(rvalid),
		.address(address),
		.bank(bank0),
		.grant_ready(bank_ready[0]),
		.grant_data(bank_data[0])
	);

	bank_arbiter #(.bank_id(1)) bank_arbiter_1 (
		.CLK(CLK),
		.RSTb(RSTb),
		.rvalid(rvalid),
		.address(address),
		.bank(bank1),
		.grant_ready(bank_ready[1]),
		.grant_data(bank_data[1])
	);

	bank_arbiter #(.bank_id(2)) bank_arbiter_2 (
		.CLK(CLK),
		.RSTb(RSTb),
		.rvalid(rvalid),
		.address(address),
		.bank(bank2),
		.grant_ready(bank_ready[2]),
		.grant_data(bank_data[2])
	);

	bank_arbiter #(.bank_id(3)) bank_arbiter_3 (
		.CLK(CLK),
		.RSTb(RSTb),
		.rvalid(rvalid),
		.address(address),
		.bank(bank3),
		.grant_ready(bank_ready[3]),
		.grant_data(bank_data[3])
	);

	// a client addresses one bank at a time, so OR is exact
	always_comb begin
		for (int c = 0; c < num_clients; c++) begin
			client_ready[c] = 1'b0;
			client_data[c] = '0;
			for (int b = 0; b < num_banks; b++) begin
				client_ready[c] = client_ready[c] | bank_ready[b][c];
				client_data[c] = client_data[c] | bank_data[b][c];
			end
		end
	end

	assign sprite.rready = client_ready[client_sprite];
	assign sprite.data = client_data[client_sprite];
	assign bg0.rready = client_ready[client_bg0];
	assign bg0.data = client_data[client_bg0];
	assign bg1.rready = client_ready[client_bg1];
	assign bg1.data = client_data[client_bg1];
	assign ov.rready = client_ready[client_ov];
	assign ov.data = client_data[client_ov];

endmodule

//--- rtl/vram_bank.sv
module vram_bank #(
	parameter int bank_id = 0
) (
	input logic CLK,
	input logic RSTb,
	vram_bank_if.bank mem,
	input logic wr_en,
	input gfx_mem_pkg::gfx_addr_t wr_addr,
	input gfx_mem_pkg::gfx_data_t wr_data
);
	import gfx_mem_pkg::*;

	gfx_data_t ram [bank_depth];
	bank_addr_t addr_q; // registered read address
	logic valid_q;
	logic wr_hit;
	logic wr_q; // write hit this bank last cycle

	assign wr_hit = wr_en && (bank_of(wr_addr) == bank_sel_w'(bank_id));

	// host write port
	always_ff @(posedge CLK) begin
		if (wr_hit) begin
			ram[offset_of(wr_addr)] <= wr_data;
		end
	end

	always_ff @(posedge CLK) begin
		addr_q <= mem.addr;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			valid_q <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			valid_q <= mem.valid;
			wr_q <= wr_hit;
		end
	end

	assign mem.dout = ram[addr_q];

	// data only trusted once the address has settled for a cycle
	assign mem.ready = valid_q && (addr_q == mem.addr) && !wr_q;

endmodule

//--- rtl/gfx_memory_subsystem.sv
module gfx_memory_subsystem (
	input logic CLK,
	input logic RSTb,

	input gfx_mem_pkg::gfx_addr_t sprite_address,
	input logic sprite_rvalid,
	output gfx_mem_pkg::gfx_data_t sprite_data,
	output logic sprite_rready,

	input gfx_mem_pkg::gfx_addr_t bg0_address,
	input logic bg0_rvalid,
	output gfx_mem_pkg::gfx_data_t bg0_data,
	output logic bg0_rready,

	input gfx_mem_pkg::gfx_addr_t bg1_address,
	input logic bg1_rvalid,
	output gfx_mem_pkg::gfx_data_t bg1_data,
	output logic bg1_rready,

	input gfx_mem_pkg::gfx_addr_t ov_address,
	input logic ov_rvalid,
	output gfx_mem_pkg::gfx_data_t ov_data,
	output logic ov_rready,

	input logic wr_en,
	input gfx_mem_pkg::gfx_addr_t wr_addr,
	input gfx_mem_pkg::gfx_data_t wr_data
);
	import gfx_mem_pkg::*;

	gfx_read_if sprite_if ();
	gfx_read_if bg0_if ();
	gfx_read_if bg1_if ();
	gfx_read_if ov_if ();

	vram_bank_if bank_if [num_banks] ();

	// client ports onto read interfaces
	assign sprite_if.address = sprite_address;
	assign sprite_if.rvalid = sprite_rvalid;
	assign sprite_data = sprite_if.data;
	assign sprite_rready = sprite_if.rready;

	assign bg0_if.address = bg0_address;
	assign bg0_if.rvalid = bg0_rvalid;
	assign bg0_data = bg0_if.data;
	assign bg0_rready = bg0_if.rready;

	assign bg1_if.address = bg1_address;
	assign bg1_if.rvalid = bg1_rvalid;
	assign bg1_data = bg1_if.data;
	assign bg1_rready = bg1_if.rready;

	assign ov_if.address = ov_address;
	assign ov_if.rvalid = ov_rvalid;
	assign ov_data = ov_if.data;
	assign ov_rready = ov_if.rready;

	gfx_memory_arbiter gfx_memory_arbiter_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.sprite(sprite_if),
		.bg0(bg0_if),
		.bg1(bg1_if),
		.ov(ov_if),
		.bank0(bank_if[0]),
		.bank1(bank_if[1]),
		.bank2(bank_if[2]),
		.bank3(bank_if[3])
	);

	// one RAM per bank, all see the host write strobes
	for (genvar b = 0; b < num_banks; b++) begin : g_bank
		vram_bank #(.bank_id(b)) vram_bank_i (
			.CLK(CLK),
			.RSTb(RSTb),
			.mem(bank_if[b]),
			.wr_en(wr_en),
			.wr_addr(wr_addr),
			.wr_data(wr_data)
		);
	end

endmodule

//--- testbench/gfx_memory_subsystem_tb.sv
module gfx_memory_subsystem_tb;
	import gfx_mem_pkg::*;

	localparam int max_lines = 64;
	localparam int fields = 7; // op mask four addresses data
	localparam int bg_writes = 16;

	typedef enum logic [3:0] {
		op_write = 4'h1,
		op_read = 4'h2,
		op_read_wr = 4'h3, // read plus host write in the same cycle
		op_end = 4'hf
	} test_op_e;

	logic CLK;
	logic RSTb;
	gfx_addr_t address [num_clients];
	logic [num_clients-1:0] rvalid;
	wire [num_clients-1:0][15:0] data;
	wire [num_clients-1:0] rready;
	logic wr_en;
	gfx_addr_t wr_addr;
	gfx_data_t wr_data;

	logic [15:0] vectors [max_lines*fields];
	gfx_data_t shadow [65536]; // mirrors every host write
	integer seed;
	int num_lines;
	int cycle_count;
	int cycle_limit;

	gfx_memory_subsystem gfx_memory_subsystem_i (
		.CLK(CLK),
		.RSTb(RSTb),
		.sprite_address(address[0]),
		.sprite_rvalid(rvalid[0]),
		.sprite_data(data[0]),
		.sprite_rready(rready[0]),
		.bg0_address(address[1]),
		.bg0_rvalid(rvalid[1]),
		.bg0_data(data[1]),
		.bg0_rready(rready[1]),
		.bg1_address(address[2]),
		.bg1_rvalid(rvalid[2]),
		.bg1_data(data[2]),
		.bg1_rready(rready[2]),
		.ov_address(address[3]),
		.ov_rvalid(rvalid[3]),
		.ov_data(data[3]),
		.ov_rready(rready[3]),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge CLK);
			cycle_count++;
			if (cycle_limit > 0 && cycle_count > cycle_limit) begin
				fail_with("timeout, the tests did not finish within the cycle limit");
			end
		end
	end

	function automatic string client_name(input int c);
		case (c)
			0: return "sprite";
			1: return "bg0";
			2: return "bg1";
			default: return "ov";
		endcase
	endfunction

	function automatic logic [1:0] bank_sel(input gfx_addr_t a);
		return a[15:14];
	endfunction

	task automatic report_mismatch(input string sig, input logic [15:0] got,
			input logic [15:0] exp);
		$display("Mismatch at %0t: %s is %h, expected %h", $time, sig, got, exp);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic fail_with(input string why);
		$display("Error at %0t: %s", $time, why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_idle();
		for (int c = 0; c < num_clients; c++) begin
			assert (rready[c] == 1'b0)
				else report_mismatch({client_name(c), "_rready"}, rready[c], 0);
			assert (data[c] == 16'h0)
				else report_mismatch({client_name(c), "_data"}, data[c], 0);
		end
	endtask

	task automatic host_write(input gfx_addr_t a, input gfx_data_t d);
		wr_en = 1'b1;
		wr_addr = a;
		wr_data = d;
		shadow[a] = d;
		@(negedge CLK);
		check_idle();
		wr_en = 1'b0;
	endtask

	task automatic run_read(input int line);
		test_op_e op;
		logic [num_clients-1:0] mask;
		logic [num_clients-1:0] pending;
		gfx_addr_t wa;
		gfx_data_t expect_xor;
		int exp_lat [num_clients];
		bit fixed_lat [num_clients];
		int cycles;
		op = test_op_e'(vectors[line*fields][3:0]);
		mask = vectors[line*fields+1][num_clients-1:0];
		wa = vectors[line*fields+5];
		for (int c = 0; c < num_clients; c++) begin
			address[c] = mask[c] ? vectors[line*fields+2+c] : 16'h0;
		end
		if (op == op_read_wr) begin
			wr_en = 1'b1;
			wr_addr = wa;
			wr_data = vectors[line*fields+6];
			shadow[wa] = wr_data;
		end
		expect_xor = '0;
		for (int c = 0; c < num_clients; c++) begin
			if (mask[c]) expect_xor ^= shadow[address[c]];
			fixed_lat[c] = 1'b1; // no other request on the same bank
			for (int o = 0; o < num_clients; o++) begin
				if (o != c && mask[o] && bank_sel(address[o]) == bank_sel(address[c])) begin
					fixed_lat[c] = 1'b0;
				end
			end
			// a write into the read bank holds ready off for one cycle
			exp_lat[c] = (op == op_read_wr && bank_sel(wa) == bank_sel(address[c])) ? 2 : 1;
		end
		if (op == op_read) begin
			assert (vectors[line*fields+6] == expect_xor)
				else report_mismatch("tests file data column", vectors[line*fields+6], expect_xor);
		end
		rvalid = mask;
		pending = mask;
		cycles = 0;
		while (pending != '0) begin
			@(negedge CLK);
			cycles++;
			for (int c = 0; c < num_clients; c++) begin
				if (!rready[c]) begin
					assert (data[c] == 16'h0)
						else report_mismatch({client_name(c), "_data"}, data[c], 0);
				end
				if (!pending[c]) begin
					assert (!rready[c]) else report_mismatch({client_name(c), "_rready"}, rready[c], 0);
				end else if (fixed_lat[c] && cycles <= exp_lat[c]) begin
					assert (rready[c] == (cycles == exp_lat[c]))
						else report_mismatch({client_name(c), "_rready"}, rready[c],
							cycles == exp_lat[c]);
				end
				for (int o = c + 1; o < num_clients; o++) begin
					if (mask[c] && mask[o] && bank_sel(address[o]) == bank_sel(address[c])) begin
						assert (!(rready[c] && rready[o]))
							else fail_with("two clients granted on one bank at once");
					end
				end
			end
			for (int c = 0; c < num_clients; c++) begin
				if (pending[c] && rready[c]) begin
					assert (data[c] == shadow[address[c]])
						else report_mismatch({client_name(c), "_data"}, data[c],
							shadow[address[c]]);
					for (int h = 0; h < c; h++) begin
						if (mask[h] && bank_sel(address[h]) == bank_sel(address[c])) begin
							assert (!pending[h])
								else fail_with("grant given ahead of a higher priority client");
						end
					end
					pending[c] = 1'b0;
				end
			end
			wr_en = 1'b0;
			rvalid = pending; // granted clients let go
		end
		@(negedge CLK);
		check_idle();
	endtask

	initial begin
		int line;
		gfx_addr_t ra;
		logic [31:0] rnd;
		RSTb = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rvalid = '0;
		for (int c = 0; c < num_clients; c++) begin
			address[c] = '0;
		end
		seed = 32'hd477;
		cycle_limit = 0;
		$readmemh("testbench/gfx_mem_tests.txt", vectors);
		num_lines = 0;
		while (num_lines < max_lines && vectors[num_lines*fields][3:0] != op_end) begin
			num_lines++;
		end
		cycle_limit = num_lines * 20 + 100;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
		for (int i = 0; i < bg_writes; i++) begin
			rnd = $random(seed);
			ra = {rnd[15:14], 1'b1, rnd[12:0]}; // upper half of a bank away from test words
			host_write(ra, rnd[31:16]);
		end
		for (line = 0; line < num_lines; line++) begin
			case (test_op_e'(vectors[line*fields][3:0]))
				op_write: host_write(vectors[line*fields+2], vectors[line*fields+6]);
				op_read, op_read_wr: run_read(line);
				default: fail_with("unknown opcode in the tests file");
			endcase
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- gfx_memory_subsystem.f
rtl/gfx_mem_pkg.sv
rtl/vram_bank_if.sv
rtl/gfx_read_if.sv
rtl/bank_arbiter.sv
rtl/gfx_memory_arbiter.sv
rtl/vram_bank.sv
rtl/gfx_memory_subsystem.sv
testbench/gfx_memory_subsystem_tb.sv

//--- testbench/gfx_mem_tests.txt
// op mask addr_sp addr_bg0 addr_bg1 addr_ov data  (mask bit 0 is sprite and bit 3 is ov)
// op 1 writes data at addr_sp, 2 reads with data the xor of read words, 3 reads and writes data at addr_ov, f ends
1 0 0010 0000 0000 0000 a001
1 0 4020 0000 0000 0000 b002
1 0 8030 0000 0000 0000 c003
1 0 c040 0000 0000 0000 d004
1 0 0011 0000 0000 0000 1111
1 0 0012 0000 0000 0000 2222
1 0 0013 0000 0000 0000 3333
1 0 4021 0000 0000 0000 5555
2 1 0010 0000 0000 0000 a001
2 1 4020 0000 0000 0000 b002
2 1 8030 0000 0000 0000 c003
2 1 c040 0000 0000 0000 d004
2 2 0000 0010 0000 0000 a001
2 2 0000 4020 0000 0000 b002
2 2 0000 8030 0000 0000 c003
2 2 0000 c040 0000 0000 d004
2 4 0000 0000 0010 0000 a001
2 4 0000 0000 4020 0000 b002
2 4 0000 0000 8030 0000 c003
2 4 0000 0000 c040 0000 d004
2 8 0000 0000 0000 0010 a001
2 8 0000 0000 0000 4020 b002
2 8 0000 0000 0000 8030 c003
2 8 0000 0000 0000 c040 d004
2 f 0010 4020 8030 c040 0004
2 f c040 8030 4020 0010 0004
2 f 0010 0011 0012 0013 a001
2 6 0000 4020 4021 0000 e557
3 1 0010 0000 0000 0010 7777
3 4 0000 0000 8030 0013 4444
3 2 0000 4020 0000 4021 6666
2 9 0010 0000 0000 0013 3333
2 1 4021 0000 0000 0000 6666
f 0 0000 0000 0000 0000 0000
